// ==== xaui_pkg.sv ====
`default_nettype none

package xaui_pkg;

  localparam int num_lanes = 4;

  // XGMII control characters.
  localparam logic [7:0] k_idle  = 8'h07;
  localparam logic [7:0] k_start = 8'hFB;
  localparam logic [7:0] k_term  = 8'hFD;
  localparam logic [7:0] k_error = 8'hFE;

  // 8b/10b special characters as seen on the transceiver side.
  localparam logic [7:0] k_sync  = 8'hBC; // K28.5, /K/.
  localparam logic [7:0] k_align = 8'h7C; // K28.3, /A/.
  localparam logic [7:0] k_seq   = 8'h9C; // K28.4, leads an ordered set.

  // Ordered sets, lane 0 in the low byte.
  localparam logic [31:0] local_fault_col  = {8'h01, 16'h0000, k_seq};
  localparam logic [31:0] remote_fault_col = {8'h02, 16'h0000, k_seq};

  localparam int align_period = 16; // Idle columns per /A/ column.

  // Lane synchronisation.
  localparam int sync_commas    = 4;
  localparam int sync_loss_errs = 4;

  // Lane deskew.
  localparam int align_columns    = 2;
  localparam int deskew_loss_errs = 4;

endpackage

`default_nettype wire

// ==== pcs_tx.sv ====
`default_nettype none

module pcs_tx (
  input  wire         usrclk,
  input  wire         reset,
  input  wire  [63:0] xgmii_txd,
  input  wire  [7:0]  xgmii_txc,
  output logic [63:0] mgt_txdata,
  output logic [7:0]  mgt_txcharisk
);

  logic [63:0] txd_q;
  logic [7:0]  txc_q;
  logic [63:0] enc_data;
  logic [7:0]  enc_k;
  int          idle_cnt;
  int          cnt_nxt;

  always_ff @(posedge usrclk) begin
    txd_q <= xgmii_txd;
    txc_q <= xgmii_txc;
  end

  // The idle counter runs across both columns, lower column first.
  always_comb begin
    enc_data = txd_q;
    enc_k    = txc_q;
    cnt_nxt  = idle_cnt;
    for (int c = 0; c < 2; c++) begin
      if (txc_q[c*xaui_pkg::num_lanes +: xaui_pkg::num_lanes] == '1 &&
          txd_q[c*8*xaui_pkg::num_lanes +: 8*xaui_pkg::num_lanes] ==
          {xaui_pkg::num_lanes{xaui_pkg::k_idle}}) begin
        if (cnt_nxt == xaui_pkg::align_period - 1) begin
          enc_data[c*8*xaui_pkg::num_lanes +: 8*xaui_pkg::num_lanes] =
            {xaui_pkg::num_lanes{xaui_pkg::k_align}};
          cnt_nxt = 0;
        end else begin
          enc_data[c*8*xaui_pkg::num_lanes +: 8*xaui_pkg::num_lanes] =
            {xaui_pkg::num_lanes{xaui_pkg::k_sync}};
          cnt_nxt = cnt_nxt + 1;
        end
      end
    end
  end

  always_ff @(posedge usrclk) begin
    if (reset) begin
      idle_cnt <= 0;
    end else begin
      idle_cnt <= cnt_nxt;
    end
  end

  always_ff @(posedge usrclk) begin
    mgt_txdata    <= enc_data;
    mgt_txcharisk <= enc_k; // Idle bytes keep their control bit as /K/ or /A/.
  end

endmodule

`default_nettype wire

// ==== pcs_sync.sv ====
`default_nettype none

module pcs_sync (
  input  wire        usrclk,
  input  wire        reset,
  input  wire  [7:0] mgt_codecomma,
  input  wire  [7:0] mgt_codevalid,
  input  wire  [3:0] mgt_syncok,
  input  wire  [3:0] mgt_rxlock,
  input  wire  [3:0] signal_detect,
  input  wire  [3:0] mgt_tx_reset,
  input  wire  [3:0] mgt_rx_reset,
  output logic [3:0] mgt_enable_align,
  output logic [3:0] sync_status
);

  typedef enum logic [1:0] {
    st_loss,
    st_comma,
    st_synced
  } sync_state_t;

  for (genvar i = 0; i < xaui_pkg::num_lanes; i++) begin : g_lane
    sync_state_t state;
    sync_state_t state_nxt;
    int          comma_cnt;
    int          comma_cnt_nxt;
    int          err_cnt;
    int          err_cnt_nxt;
    logic        code_ok;
    logic        comma_ok;
    logic        lane_ok;
    logic        en_q;

    // A lane owns bytes i and i+4.
    assign code_ok  = mgt_codevalid[i] & mgt_codevalid[i+xaui_pkg::num_lanes];
    assign comma_ok = (mgt_codecomma[i] | mgt_codecomma[i+xaui_pkg::num_lanes]) &
                      code_ok & mgt_syncok[i];
    assign lane_ok  = mgt_rxlock[i] & signal_detect[i] & ~mgt_tx_reset[i] & ~mgt_rx_reset[i];

    always_comb begin
      state_nxt     = state;
      comma_cnt_nxt = comma_cnt;
      err_cnt_nxt   = 0;
      if (!lane_ok) begin
        state_nxt     = st_loss;
        comma_cnt_nxt = 0;
      end else begin
        case (state)
          st_loss: begin
            if (comma_ok) begin
              state_nxt     = st_comma;
              comma_cnt_nxt = 1;
            end
          end
          st_comma: begin
            if (!code_ok) begin
              state_nxt     = st_loss; // A bad code restarts the comma search.
              comma_cnt_nxt = 0;
            end else if (comma_ok) begin
              if (comma_cnt >= xaui_pkg::sync_commas - 1) begin
                state_nxt     = st_synced;
                comma_cnt_nxt = 0;
              end else begin
                comma_cnt_nxt = comma_cnt + 1;
              end
            end
          end
          st_synced: begin
            if (!code_ok) begin
              if (err_cnt >= xaui_pkg::sync_loss_errs - 1) begin
                state_nxt = st_loss;
              end else begin
                err_cnt_nxt = err_cnt + 1;
              end
            end
          end
          default: state_nxt = st_loss;
        endcase
      end
    end

    always_ff @(posedge usrclk) begin
      if (reset) begin
        state     <= st_loss;
        comma_cnt <= 0;
        err_cnt   <= 0;
        en_q      <= 1'b0;
      end else begin
        state     <= state_nxt;
        comma_cnt <= comma_cnt_nxt;
        err_cnt   <= err_cnt_nxt;
        en_q      <= (state_nxt != st_synced); // Follows the state, so never set while synced.
      end
    end

    assign mgt_enable_align[i] = en_q;
    assign sync_status[i]      = (state == st_synced);
  end

endmodule

`default_nettype wire

// ==== pcs_deskew.sv ====
`default_nettype none

module pcs_deskew (
  input  wire         usrclk,
  input  wire         reset,
  input  wire  [63:0] mgt_rxdata,
  input  wire  [7:0]  mgt_rxcharisk,
  input  wire  [7:0]  mgt_codevalid,
  input  wire  [3:0]  sync_status,
  output logic        mgt_enchansync,
  output logic        align_status
);

  logic       all_sync;
  logic       any_err;
  logic       align_q;
  logic       part_a;
  logic [7:0] a_byte;
  logic [1:0] col_all;
  logic [1:0] col_any;
  int         full_a;
  int         a_cnt;
  int         err_cnt;

  always_comb begin
    for (int b = 0; b < 2*xaui_pkg::num_lanes; b++) begin
      a_byte[b] = mgt_rxcharisk[b] && (mgt_rxdata[8*b +: 8] == xaui_pkg::k_align);
    end
    for (int c = 0; c < 2; c++) begin
      col_all[c] = &a_byte[c*xaui_pkg::num_lanes +: xaui_pkg::num_lanes];
      col_any[c] = |a_byte[c*xaui_pkg::num_lanes +: xaui_pkg::num_lanes];
    end
    full_a = int'(col_all[0]) + int'(col_all[1]);
    part_a = |(col_any & ~col_all); // /A/ on some lanes only means the lanes disagree.
  end

  assign all_sync       = &sync_status;
  assign any_err        = ~&mgt_codevalid;
  assign mgt_enchansync = all_sync;
  assign align_status   = align_q & all_sync; // A lane losing sync drops alignment at once.

  always_ff @(posedge usrclk) begin
    if (reset || !all_sync) begin
      align_q <= 1'b0;
      a_cnt   <= 0;
      err_cnt <= 0;
    end else if (!align_q) begin
      err_cnt <= 0;
      if (part_a) begin
        a_cnt <= 0;
      end else if (a_cnt + full_a >= xaui_pkg::align_columns) begin
        align_q <= 1'b1;
        a_cnt   <= 0;
      end else begin
        a_cnt <= a_cnt + full_a;
      end
    end else if (any_err) begin
      if (err_cnt >= xaui_pkg::deskew_loss_errs - 1) begin
        align_q <= 1'b0;
        err_cnt <= 0;
      end else begin
        err_cnt <= err_cnt + 1;
      end
    end else begin
      err_cnt <= 0; // Only consecutive errored cycles count.
    end
  end

endmodule

`default_nettype wire

// ==== pcs_rx.sv ====
`default_nettype none

module pcs_rx (
  input  wire         usrclk,
  input  wire         reset,
  input  wire  [63:0] mgt_rxdata,
  input  wire  [7:0]  mgt_rxcharisk,
  input  wire  [7:0]  mgt_codevalid,
  input  wire         align_status,
  output logic [63:0] xgmii_rxd,
  output logic [7:0]  xgmii_rxc
);

  logic [63:0] dec_data;
  logic [7:0]  dec_c;

  always_ff @(posedge usrclk) begin
    for (int b = 0; b < 2*xaui_pkg::num_lanes; b++) begin
      if (!mgt_codevalid[b]) begin
        dec_data[8*b +: 8] <= xaui_pkg::k_error;
        dec_c[b]           <= 1'b1;
      end else if (mgt_rxcharisk[b] &&
                   (mgt_rxdata[8*b +: 8] == xaui_pkg::k_sync ||
                    mgt_rxdata[8*b +: 8] == xaui_pkg::k_align)) begin
        dec_data[8*b +: 8] <= xaui_pkg::k_idle; // No /R/ here, so /K/ and /A/ are all of idle.
        dec_c[b]           <= 1'b1;
      end else begin
        dec_data[8*b +: 8] <= mgt_rxdata[8*b +: 8];
        dec_c[b]           <= mgt_rxcharisk[b];
      end
    end
  end

  // Only the sequence character of the ordered set is a control byte.
  always_ff @(posedge usrclk) begin
    if (reset || !align_status) begin
      xgmii_rxd <= {2{xaui_pkg::local_fault_col}};
      xgmii_rxc <= {2{4'b0001}};
    end else begin
      xgmii_rxd <= dec_data;
      xgmii_rxc <= dec_c;
    end
  end

endmodule

`default_nettype wire

// ==== xaui_status_ctrl.sv ====
`default_nettype none

module xaui_status_ctrl (
  input  wire         usrclk,
  input  wire         reset,
  input  wire  [6:0]  configuration_vector,
  input  wire  [63:0] xgmii_rxd,
  input  wire  [7:0]  xgmii_rxc,
  input  wire         align_status,
  input  wire  [3:0]  sync_status,
  output logic        mgt_loopback,
  output logic        mgt_powerdown,
  output logic [7:0]  status_vector
);

  logic [3:2] cfg_q;
  logic [3:2] cfg_qq;
  logic       clr_fault;
  logic       sample_link;
  logic       remote_seen;
  logic       local_fault;
  logic       remote_fault;
  logic       rx_link_up;

  assign mgt_loopback  = configuration_vector[0];
  assign mgt_powerdown = configuration_vector[1];

  assign clr_fault   = cfg_q[2] & ~cfg_qq[2];
  assign sample_link = cfg_q[3] & ~cfg_qq[3];

  always_comb begin
    remote_seen = 1'b0;
    for (int c = 0; c < 2; c++) begin
      if (xgmii_rxc[4*c +: 4] == 4'b0001 &&
          xgmii_rxd[32*c +: 32] == xaui_pkg::remote_fault_col) begin
        remote_seen = 1'b1;
      end
    end
  end

  always_ff @(posedge usrclk) begin
    if (reset) begin
      cfg_q        <= '0;
      cfg_qq       <= '0;
      local_fault  <= 1'b1;
      remote_fault <= 1'b0;
      rx_link_up   <= 1'b0;
    end else begin
      cfg_q  <= configuration_vector[3:2];
      cfg_qq <= cfg_q;

      if (!align_status) begin
        local_fault <= 1'b1; // Held set for as long as the lanes are not aligned.
      end else if (clr_fault) begin
        local_fault <= 1'b0;
      end

      if (remote_seen) begin
        remote_fault <= 1'b1;
      end else if (clr_fault) begin
        remote_fault <= 1'b0;
      end

      if (!align_status) begin
        rx_link_up <= 1'b0;
      end else if (sample_link) begin
        rx_link_up <= align_status;
      end
    end
  end

  assign status_vector = {rx_link_up, align_status, sync_status, local_fault, remote_fault};

endmodule

`default_nettype wire

// ==== xaui_kat.sv ====
`default_nettype none

module xaui_kat (
  input  wire         reset,
  input  wire         usrclk,
  // Client side.
  input  wire  [63:0] xgmii_txd,
  input  wire  [7:0]  xgmii_txc,
  output wire  [63:0] xgmii_rxd,
  output wire  [7:0]  xgmii_rxc,
  // Transceiver side.
  output wire  [63:0] mgt_txdata,
  output wire  [7:0]  mgt_txcharisk,
  input  wire  [63:0] mgt_rxdata,
  input  wire  [7:0]  mgt_rxcharisk,
  input  wire  [7:0]  mgt_codevalid,
  input  wire  [7:0]  mgt_codecomma,
  output wire  [3:0]  mgt_enable_align,
  output wire         mgt_enchansync,
  input  wire  [3:0]  mgt_syncok,
  output wire         mgt_loopback,
  output wire         mgt_powerdown,
  input  wire  [3:0]  mgt_rxlock,
  // Status and configuration.
  input  wire  [6:0]  configuration_vector,
  output wire  [7:0]  status_vector,
  output wire         align_status,
  output wire  [3:0]  sync_status,
  input  wire  [3:0]  mgt_tx_reset,
  input  wire  [3:0]  mgt_rx_reset,
  input  wire  [3:0]  signal_detect
);

  pcs_tx i_pcs_tx (
    .usrclk        (usrclk),
    .reset         (reset),
    .xgmii_txd     (xgmii_txd),
    .xgmii_txc     (xgmii_txc),
    .mgt_txdata    (mgt_txdata),
    .mgt_txcharisk (mgt_txcharisk)
  );

  pcs_sync i_pcs_sync (
    .usrclk           (usrclk),
    .reset            (reset),
    .mgt_codecomma    (mgt_codecomma),
    .mgt_codevalid    (mgt_codevalid),
    .mgt_syncok       (mgt_syncok),
    .mgt_rxlock       (mgt_rxlock),
    .signal_detect    (signal_detect),
    .mgt_tx_reset     (mgt_tx_reset),
    .mgt_rx_reset     (mgt_rx_reset),
    .mgt_enable_align (mgt_enable_align),
    .sync_status      (sync_status)
  );

  pcs_deskew i_pcs_deskew (
    .usrclk         (usrclk),
    .reset          (reset),
    .mgt_rxdata     (mgt_rxdata),
    .mgt_rxcharisk  (mgt_rxcharisk),
    .mgt_codevalid  (mgt_codevalid),
    .sync_status    (sync_status),
    .mgt_enchansync (mgt_enchansync),
    .align_status   (align_status)
  );

  pcs_rx i_pcs_rx (
    .usrclk        (usrclk),
    .reset         (reset),
    .mgt_rxdata    (mgt_rxdata),
    .mgt_rxcharisk (mgt_rxcharisk),
    .mgt_codevalid (mgt_codevalid),
    .align_status  (align_status),
    .xgmii_rxd     (xgmii_rxd),
    .xgmii_rxc     (xgmii_rxc)
  );

  xaui_status_ctrl i_xaui_status_ctrl (
    .usrclk               (usrclk),
    .reset                (reset),
    .configuration_vector (configuration_vector),
    .xgmii_rxd            (xgmii_rxd),
    .xgmii_rxc            (xgmii_rxc),
    .align_status         (align_status),
    .sync_status          (sync_status),
    .mgt_loopback         (mgt_loopback),
    .mgt_powerdown        (mgt_powerdown),
    .status_vector        (status_vector)
  );

endmodule

`default_nettype wire

// ==== xaui_kat_asserts.sv ====
`default_nettype none

module xaui_kat_asserts (
  input wire       usrclk,
  input wire       reset,
  input wire       align_status,
  input wire       mgt_enchansync,
  input wire [3:0] sync_status,
  input wire [3:0] mgt_enable_align
);

  timeunit 1ns;
  timeprecision 1ps;

  // Alignment is only meaningful once every lane is synchronised.
  align_needs_sync: assert property (@(posedge usrclk) disable iff (reset)
    align_status |-> (&sync_status))
    else $error("align_status high while a lane is not synchronised");

  align_needs_chansync: assert property (@(posedge usrclk) disable iff (reset)
    align_status |-> mgt_enchansync)
    else $error("align_status high without mgt_enchansync");

  enable_align_unsynced: assert property (@(posedge usrclk) disable iff (reset)
    (mgt_enable_align & sync_status) == 4'b0000)
    else $error("mgt_enable_align high on a synchronised lane");

endmodule

bind xaui_kat xaui_kat_asserts i_xaui_kat_asserts (
  .usrclk           (usrclk),
  .reset            (reset),
  .align_status     (align_status),
  .mgt_enchansync   (mgt_enchansync),
  .sync_status      (sync_status),
  .mgt_enable_align (mgt_enable_align)
);

`default_nettype wire

// ==== tb_clkgen.sv ====
`default_nettype none

module tb_clkgen (
  output logic usrclk
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    usrclk = 1'b0;
  end

  always #5 usrclk = ~usrclk; // 10 ns period.

endmodule

`default_nettype wire

// ==== tb_xaui_kat.sv ====
`default_nettype none

module tb_xaui_kat;

  timeunit 1ns;
  timeprecision 1ps;

  wire         usrclk;
  logic        reset;
  logic [63:0] xgmii_txd;
  logic [7:0]  xgmii_txc;
  logic [7:0]  mgt_codevalid;
  logic [6:0]  configuration_vector;
  logic [3:0]  signal_detect;
  wire  [63:0] xgmii_rxd;
  wire  [7:0]  xgmii_rxc;
  wire  [63:0] mgt_txdata;
  wire  [7:0]  mgt_txcharisk;
  logic [7:0]  mgt_codecomma;
  wire  [3:0]  mgt_enable_align;
  wire         mgt_enchansync;
  wire         mgt_loopback;
  wire         mgt_powerdown;
  wire  [7:0]  status_vector;
  wire         align_status;
  wire  [3:0]  sync_status;

  string       test_name = "reset";
  logic        check_on = 1'b0;
  logic        prev_align = 1'b0;
  int          data_errors = 0;
  int          check_errors = 0;
  logic [63:0] td_pipe [4];
  logic [7:0]  tc_pipe [4];
  logic [7:0]  err_pipe [2];

  tb_clkgen i_tb_clkgen (.usrclk(usrclk));

  // The transceivers are looped back, and a comma is any /K/ byte on the wire.
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      mgt_codecomma[b] = mgt_txcharisk[b] && (mgt_txdata[8*b +: 8] == xaui_pkg::k_sync);
    end
  end

  xaui_kat i_xaui_kat (
    .reset (reset), .usrclk (usrclk),
    .xgmii_txd (xgmii_txd), .xgmii_txc (xgmii_txc),
    .xgmii_rxd (xgmii_rxd), .xgmii_rxc (xgmii_rxc),
    .mgt_txdata (mgt_txdata), .mgt_txcharisk (mgt_txcharisk),
    .mgt_rxdata (mgt_txdata), .mgt_rxcharisk (mgt_txcharisk),
    .mgt_codevalid (mgt_codevalid), .mgt_codecomma (mgt_codecomma),
    .mgt_enable_align (mgt_enable_align), .mgt_enchansync (mgt_enchansync),
    .mgt_syncok (4'hF), .mgt_loopback (mgt_loopback),
    .mgt_powerdown (mgt_powerdown), .mgt_rxlock (4'hF),
    .configuration_vector (configuration_vector), .status_vector (status_vector),
    .align_status (align_status), .sync_status (sync_status),
    .mgt_tx_reset (4'h0), .mgt_rx_reset (4'h0), .signal_detect (signal_detect)
  );

  // Idle columns come back as idle, so only code errors and stray /K/ or /A/ change a byte.
  function automatic logic [71:0] rx_model(input logic [63:0] txd, input logic [7:0] txc,
                                           input logic [7:0] err);
    logic [63:0] d;
    logic [7:0]  c;
    d = txd;
    c = txc;
    for (int b = 0; b < 8; b++) begin
      if (err[b]) begin
        d[8*b +: 8] = xaui_pkg::k_error;
        c[b]        = 1'b1;
      end else if (txc[b] && (txd[8*b +: 8] == xaui_pkg::k_sync ||
                              txd[8*b +: 8] == xaui_pkg::k_align)) begin
        d[8*b +: 8] = xaui_pkg::k_idle;
      end
    end
    return {c, d};
  endfunction

  always @(negedge usrclk) begin
    logic [71:0] exp_v;
    logic [71:0] act_v;
    if (check_on) begin
      if (prev_align) begin
        exp_v = rx_model(td_pipe[3], tc_pipe[3], err_pipe[1]);
      end else begin
        exp_v = {{2{4'b0001}}, {2{xaui_pkg::local_fault_col}}};
      end
      act_v = {xgmii_rxc, xgmii_rxd};
      assert (act_v === exp_v) else begin
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp_v, act_v);
        data_errors++;
      end
    end
    prev_align = align_status;
    for (int i = 3; i > 0; i--) begin
      td_pipe[i] = td_pipe[i-1];
      tc_pipe[i] = tc_pipe[i-1];
    end
    td_pipe[0]  = xgmii_txd;
    tc_pipe[0]  = xgmii_txc;
    err_pipe[1] = err_pipe[0];
    err_pipe[0] = ~mgt_codevalid;
  end

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic wait_status(input logic [7:0] mask, input logic [7:0] value,
                             input int limit, input string what);
    int n;
    n = 0;
    @(negedge usrclk);
    while ((status_vector & mask) != value && n < limit) begin
      @(negedge usrclk);
      n++;
    end
    assert ((status_vector & mask) == value) else begin
      $display("Timeout: %s did not happen within %0d cycles", what, limit);
      check_errors++;
    end
  endtask

  task automatic send_word(input logic [63:0] d, input logic [7:0] c);
    @(posedge usrclk);
    xgmii_txd <= d;
    xgmii_txc <= c;
  endtask

  task automatic send_idle(input int n);
    repeat (n) send_word({8{xaui_pkg::k_idle}}, 8'hFF);
  endtask

  task automatic send_frame(input int len);
    logic [63:0] d;
    d = {$urandom, $urandom};
    send_word({d[63:8], xaui_pkg::k_start}, 8'h01);
    repeat (len) send_word({$urandom, $urandom}, 8'h00);
    d = {$urandom, $urandom};
    send_word({{3{xaui_pkg::k_idle}}, xaui_pkg::k_term, d[31:0]}, 8'hF0);
  endtask

  task automatic pulse_cfg(input int idx);
    @(posedge usrclk);
    configuration_vector[idx] <= 1'b1;
    @(posedge usrclk);
    configuration_vector[idx] <= 1'b0;
  endtask

  initial begin
    int b;
    void'($urandom(99));
    reset                <= 1'b1;
    xgmii_txd            <= {8{xaui_pkg::k_idle}};
    xgmii_txc            <= 8'hFF;
    mgt_codevalid        <= 8'hFF;
    configuration_vector <= 7'd0;
    signal_detect        <= 4'hF;
    repeat (10) @(posedge usrclk);
    reset    <= 1'b0;
    check_on = 1'b1;

    test_name = "bring-up";
    @(negedge usrclk);
    @(negedge usrclk); // One cycle out of reset, far short of sync_commas commas.
    check_val("enable_align before sync", 64'(4'hF), 64'(mgt_enable_align));
    check_val("enchansync before sync", 64'(0), 64'(mgt_enchansync));
    check_val("sync_status before sync", 64'(0), 64'(sync_status));
    wait_status(8'h3C, 8'h3C, 100, "lane sync on all lanes");
    check_val("sync_status after sync", 64'(4'hF), 64'(sync_status));
    check_val("enable_align after sync", 64'(0), 64'(mgt_enable_align));
    check_val("enchansync after sync", 64'(1), 64'(mgt_enchansync));
    wait_status(8'h40, 8'h40, 200, "lane alignment");
    check_val("bring-up local fault", 64'(1), 64'(status_vector[1]));

    test_name = "data path";
    for (int f = 0; f < 20; f++) begin
      send_frame($urandom_range(12, 1));
      send_idle($urandom_range(4, 1));
    end
    send_idle(4);
    check_val("data path alignment", 64'(1), 64'(align_status));

    test_name = "code errors";
    for (int k = 0; k < 6; k++) begin
      b = $urandom_range(7, 0);
      @(posedge usrclk);
      mgt_codevalid <= ~(8'h01 << b); // One bad byte for one cycle.
      @(posedge usrclk);
      mgt_codevalid <= 8'hFF;
      @(posedge usrclk);
      @(negedge usrclk);
      check_val("code error byte", 64'({1'b1, xaui_pkg::k_error}),
                64'({xgmii_rxc[b], xgmii_rxd[8*b +: 8]}));
      send_frame(3);
      send_idle(2);
    end
    check_val("code errors alignment", 64'(1), 64'(align_status));

    test_name = "status and configuration";
    pulse_cfg(3);
    wait_status(8'h80, 8'h80, 10, "rx_link_up after link sample");
    pulse_cfg(2);
    wait_status(8'h02, 8'h00, 10, "local fault clear");
    for (int v = 3; v >= 0; v--) begin
      @(posedge usrclk);
      configuration_vector[1:0] <= v[1:0];
      @(negedge usrclk);
      check_val("mgt_loopback", 64'(v[0]), 64'(mgt_loopback));
      check_val("mgt_powerdown", 64'(v[1]), 64'(mgt_powerdown));
    end
    send_word({{4{xaui_pkg::k_idle}}, xaui_pkg::remote_fault_col}, 8'hF1);
    send_idle(1);
    wait_status(8'h01, 8'h01, 10, "remote fault latch");
    pulse_cfg(2);
    wait_status(8'h01, 8'h00, 10, "remote fault clear");

    test_name = "loss and recovery";
    @(posedge usrclk);
    signal_detect[2] <= 1'b0;
    wait_status(8'h50, 8'h00, 5, "lane 2 sync and alignment drop");
    check_val("sync_status lane 2 lost", 64'(4'b1011), 64'(sync_status));
    check_val("enable_align lane 2 lost", 64'(4'b0100), 64'(mgt_enable_align));
    check_val("enchansync lane 2 lost", 64'(0), 64'(mgt_enchansync));
    wait_status(8'h82, 8'h02, 5, "local fault set and link down");
    repeat (5) @(posedge usrclk);
    signal_detect[2] <= 1'b1;
    wait_status(8'h7C, 8'h7C, 200, "realignment after signal detect");
    check_val("enable_align after recovery", 64'(0), 64'(mgt_enable_align));
    check_val("enchansync after recovery", 64'(1), 64'(mgt_enchansync));
    pulse_cfg(2);
    wait_status(8'h02, 8'h00, 10, "local fault clear after recovery");
    send_idle(6);

    check_on = 1'b0;
    $display("Errors: data path %0d, status checks %0d", data_errors, check_errors);
    if (data_errors == 0 && check_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
xaui_pkg.sv
pcs_tx.sv
pcs_sync.sv
pcs_deskew.sv
pcs_rx.sv
xaui_status_ctrl.sv
xaui_kat.sv
xaui_kat_asserts.sv
tb_clkgen.sv
tb_xaui_kat.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_xaui_kat
FILELIST   := sources.f
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON)
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
